// File: logic/axiLitePkg.sv
`default_nettype none

package axiLitePkg;

  ////////////////////////////////////////
  // bus response codes
  ////////////////////////////////////////

  // two-bit code on bResp and rResp
  typedef logic [1:0] respT;

  // access completed
  localparam respT RespOkay = 2'b00;
  // access refused by the register bank
  localparam respT RespSlvErr = 2'b10;

  // progress of one write through the aw and w channels
  typedef enum logic [1:0] {
    wrIdle,
    wrHaveAddr,
    wrHaveData,
    wrResp
  } wrStateT;

  // fixed word returned from index 0
  localparam logic [31:0] IdValue = 32'h5241_0001;

  // defaults picked up by the top level
  localparam int unsigned DefaultAddrWidth = 12;
  localparam int unsigned DefaultDataWidth = 32;
  localparam int unsigned DefaultNumRegs = 8;

endpackage

`default_nettype wire

// File: logic/axiLiteSlave.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteSlave #(
  parameter int unsigned AddrWidth = 12,
  parameter int unsigned DataWidth = 32
) (
  input  wire                                         intf,
  input  wire                                         rst,
  // write address
  input  wire  [AddrWidth-1:0]                        awAddr,
  input  wire  [2:0]                                  awProt,
  input  wire                                         awValid,
  output logic                                        awReady,
  // write data
  input  wire  [DataWidth-1:0]                        wData,
  input  wire  [DataWidth/8-1:0]                      wStrb,
  input  wire                                         wValid,
  output logic                                        wReady,
  // write response
  output axiLitePkg::respT                            bResp,
  output logic                                        bValid,
  input  wire                                         bReady,
  // read address
  input  wire  [AddrWidth-1:0]                        arAddr,
  input  wire  [2:0]                                  arProt,
  input  wire                                         arValid,
  output logic                                        arReady,
  // read data
  output logic [DataWidth-1:0]                        rData,
  output axiLitePkg::respT                            rResp,
  output logic                                        rValid,
  input  wire                                         rReady,
  // register bank side
  output logic                                        regWrEn,
  output logic [AddrWidth-$clog2(DataWidth/8)-1:0]    regWrIndex,
  output logic [DataWidth-1:0]                        regWrData,
  output logic [DataWidth/8-1:0]                      regWrStrb,
  input  wire  axiLitePkg::respT                      regWrResp,
  output logic                                        regRdEn,
  output logic [AddrWidth-$clog2(DataWidth/8)-1:0]    regRdIndex,
  input  wire  [DataWidth-1:0]                        regRdData,
  input  wire  axiLitePkg::respT                      regRdResp
);

  // byte lanes per word
  localparam int unsigned StrbWidth = DataWidth / 8;
  // address bits below the word index
  localparam int unsigned OffsetBits = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;
  typedef logic [StrbWidth-1:0] strbT;

  // beat transfers this cycle
  logic awHs;
  logic wHs;
  logic bHs;
  logic arHs;
  logic rHs;

  assign awHs = awValid && awReady;
  assign wHs = wValid && wReady;
  assign bHs = bValid && bReady;
  assign arHs = arValid && arReady;
  assign rHs = rValid && rReady;

  // awProt and arProt are taken but carry no meaning here

  ////////////////////////////////////////
  // write path
  ////////////////////////////////////////

  axiLitePkg::wrStateT wrState;
  axiLitePkg::wrStateT wrNext;

  // held beats, either may come first
  addrT awAddrQ;
  dataT wDataQ;
  strbT wStrbQ;

  // strobe cycle, also first cycle of bValid
  logic wrEnQ;
  // response kept for the rest of the b beat
  axiLitePkg::respT bRespQ;

  always_comb begin
    wrNext = wrState;
    case (wrState)
      axiLitePkg::wrIdle: begin
        // both beats on one edge go straight to the response
        if (awHs && wHs) begin
          wrNext = axiLitePkg::wrResp;
        end else if (awHs) begin
          wrNext = axiLitePkg::wrHaveAddr;
        end else if (wHs) begin
          wrNext = axiLitePkg::wrHaveData;
        end
      end
      axiLitePkg::wrHaveAddr: begin
        // waiting on data only
        if (wHs) begin
          wrNext = axiLitePkg::wrResp;
        end
      end
      axiLitePkg::wrHaveData: begin
        // waiting on address only
        if (awHs) begin
          wrNext = axiLitePkg::wrResp;
        end
      end
      axiLitePkg::wrResp: begin
        if (bHs) begin
          wrNext = axiLitePkg::wrIdle;
        end
      end
      default: begin
        wrNext = axiLitePkg::wrIdle;
      end
    endcase
  end

  always_ff @(posedge intf) begin
    if (rst) begin
      wrState <= axiLitePkg::wrIdle;
      awReady <= 1'b0;
      wReady <= 1'b0;
      wrEnQ <= 1'b0;
    end else begin
      wrState <= wrNext;
      // readies follow the state being entered
      awReady <= (wrNext == axiLitePkg::wrIdle) || (wrNext == axiLitePkg::wrHaveData);
      wReady <= (wrNext == axiLitePkg::wrIdle) || (wrNext == axiLitePkg::wrHaveAddr);
      // single pulse on entry to wrResp
      wrEnQ <= (wrNext == axiLitePkg::wrResp) && (wrState != axiLitePkg::wrResp);
    end
  end

  // beat payloads
  always_ff @(posedge intf) begin
    if (awHs) begin
      awAddrQ <= awAddr;
    end
    if (wHs) begin
      wDataQ <= wData;
      wStrbQ <= wStrb;
    end
    if (wrEnQ) begin
      bRespQ <= regWrResp;
    end
  end

  assign bValid = (wrState == axiLitePkg::wrResp);
  // bank answer straight through in the strobe cycle, held copy after it
  assign bResp = wrEnQ ? regWrResp : bRespQ;

  assign regWrEn = wrEnQ;
  assign regWrIndex = awAddrQ[AddrWidth-1:OffsetBits];
  assign regWrData = wDataQ;
  assign regWrStrb = wStrbQ;

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  logic rValidQ;
  logic rValidNext;
  // strobe cycle, also first cycle of rValid
  logic rdEnQ;
  addrT arAddrQ;
  dataT rDataQ;
  axiLitePkg::respT rRespQ;

  // arReady low while a response waits, so no overlap of the two
  always_comb begin
    rValidNext = rValidQ;
    if (rHs) begin
      rValidNext = 1'b0;
    end
    if (arHs) begin
      rValidNext = 1'b1;
    end
  end

  always_ff @(posedge intf) begin
    if (rst) begin
      rValidQ <= 1'b0;
      arReady <= 1'b0;
      rdEnQ <= 1'b0;
    end else begin
      rValidQ <= rValidNext;
      arReady <= !rValidNext;
      rdEnQ <= arHs;
    end
  end

  always_ff @(posedge intf) begin
    if (arHs) begin
      arAddrQ <= arAddr;
    end
    // keep bank answer for a stalled r beat
    if (rdEnQ) begin
      rDataQ <= regRdData;
      rRespQ <= regRdResp;
    end
  end

  assign rValid = rValidQ;
  assign rData = rdEnQ ? regRdData : rDataQ;
  assign rResp = rdEnQ ? regRdResp : rRespQ;

  assign regRdEn = rdEnQ;
  assign regRdIndex = arAddrQ[AddrWidth-1:OffsetBits];

endmodule

`default_nettype wire

// File: logic/regBank.sv
`timescale 1ns/1ps
`default_nettype none

module regBank #(
  parameter int unsigned AddrWidth = 12,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumRegs = 8
) (
  input  wire                                         intf,
  input  wire                                         rst,
  // write strobe side
  input  wire                                         regWrEn,
  input  wire  [AddrWidth-$clog2(DataWidth/8)-1:0]    regWrIndex,
  input  wire  [DataWidth-1:0]                        regWrData,
  input  wire  [DataWidth/8-1:0]                      regWrStrb,
  output axiLitePkg::respT                            regWrResp,
  // read strobe side
  input  wire                                         regRdEn,
  input  wire  [AddrWidth-$clog2(DataWidth/8)-1:0]    regRdIndex,
  output logic [DataWidth-1:0]                        regRdData,
  output axiLitePkg::respT                            regRdResp
);

  localparam int unsigned StrbWidth = DataWidth / 8;
  // first general read/write index
  localparam int unsigned FirstRw = 2;
  // count of general registers
  localparam int unsigned NumRw = NumRegs - FirstRw;

  typedef logic [DataWidth-1:0] wordT;

  // general registers, slot 0 is index 2
  wordT rwRegs [NumRw];
  // successful writes, wraps
  wordT wrCount;

  logic wrLegal;
  wordT wrOld;
  wordT wrMerged;
  wordT rdWord;
  logic rdLegal;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // id and counter are read only, beyond NumRegs is nothing
  assign wrLegal = (32'(regWrIndex) >= FirstRw) && (32'(regWrIndex) < NumRegs);
  assign regWrResp = wrLegal ? axiLitePkg::RespOkay : axiLitePkg::RespSlvErr;

  // current contents of the addressed register
  always_comb begin
    wrOld = '0;
    for (int r = 0; r < NumRw; r++) begin
      if (32'(regWrIndex) == r + FirstRw) begin
        wrOld = rwRegs[r];
      end
    end
  end

  // byte lanes with strobe take new data, the rest keep old
  always_comb begin
    for (int b = 0; b < StrbWidth; b++) begin
      wrMerged[b*8 +: 8] = regWrStrb[b] ? regWrData[b*8 +: 8] : wrOld[b*8 +: 8];
    end
  end

  always_ff @(posedge intf) begin
    if (rst) begin
      wrCount <= '0;
      for (int r = 0; r < NumRw; r++) begin
        rwRegs[r] <= '0;
      end
    end else if (regWrEn && wrLegal) begin
      // refused writes never reach here
      wrCount <= wrCount + 1'b1;
      for (int r = 0; r < NumRw; r++) begin
        if (32'(regWrIndex) == r + FirstRw) begin
          rwRegs[r] <= wrMerged;
        end
      end
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  always_comb begin
    rdWord = '0;
    rdLegal = 1'b1;
    if (32'(regRdIndex) == 0) begin
      // id, zero extended for wide buses
      rdWord = DataWidth'(axiLitePkg::IdValue);
    end else if (32'(regRdIndex) == 1) begin
      rdWord = wrCount;
    end else if (32'(regRdIndex) < NumRegs) begin
      for (int r = 0; r < NumRw; r++) begin
        if (32'(regRdIndex) == r + FirstRw) begin
          rdWord = rwRegs[r];
        end
      end
    end else begin
      // out of range, zero data
      rdLegal = 1'b0;
    end
  end

  // data only driven in the strobe cycle
  assign regRdData = regRdEn ? rdWord : '0;
  assign regRdResp = rdLegal ? axiLitePkg::RespOkay : axiLitePkg::RespSlvErr;

endmodule

`default_nettype wire

// File: logic/regSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module regSubsystem #(
  parameter int unsigned AddrWidth = axiLitePkg::DefaultAddrWidth,
  parameter int unsigned DataWidth = axiLitePkg::DefaultDataWidth,
  parameter int unsigned NumRegs = axiLitePkg::DefaultNumRegs
) (
  input  wire                        intf,
  input  wire                        rst,
  // write address
  input  wire  [AddrWidth-1:0]       awAddr,
  input  wire  [2:0]                 awProt,
  input  wire                        awValid,
  output logic                       awReady,
  // write data
  input  wire  [DataWidth-1:0]       wData,
  input  wire  [DataWidth/8-1:0]     wStrb,
  input  wire                        wValid,
  output logic                       wReady,
  // write response
  output axiLitePkg::respT           bResp,
  output logic                       bValid,
  input  wire                        bReady,
  // read address
  input  wire  [AddrWidth-1:0]       arAddr,
  input  wire  [2:0]                 arProt,
  input  wire                        arValid,
  output logic                       arReady,
  // read data
  output logic [DataWidth-1:0]       rData,
  output axiLitePkg::respT           rResp,
  output logic                       rValid,
  input  wire                        rReady
);

  // word index width, byte offset dropped
  localparam int unsigned IndexWidth = AddrWidth - $clog2(DataWidth / 8);

  // strobe bus between engine and bank
  logic                   regWrEn;
  logic [IndexWidth-1:0]  regWrIndex;
  logic [DataWidth-1:0]   regWrData;
  logic [DataWidth/8-1:0] regWrStrb;
  axiLitePkg::respT       regWrResp;
  logic                   regRdEn;
  logic [IndexWidth-1:0]  regRdIndex;
  logic [DataWidth-1:0]   regRdData;
  axiLitePkg::respT       regRdResp;

  axiLiteSlave #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth)
  ) slave0 (
    .intf(intf), .rst(rst),
    .awAddr(awAddr), .awProt(awProt), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arProt(arProt), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
    .regWrEn(regWrEn), .regWrIndex(regWrIndex), .regWrData(regWrData),
    .regWrStrb(regWrStrb), .regWrResp(regWrResp),
    .regRdEn(regRdEn), .regRdIndex(regRdIndex), .regRdData(regRdData),
    .regRdResp(regRdResp)
  );

  // bank sees the same address split as the engine
  regBank #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .NumRegs(NumRegs)
  ) bank0 (
    .intf(intf), .rst(rst),
    .regWrEn(regWrEn), .regWrIndex(regWrIndex), .regWrData(regWrData),
    .regWrStrb(regWrStrb), .regWrResp(regWrResp),
    .regRdEn(regRdEn), .regRdIndex(regRdIndex), .regRdData(regRdData),
    .regRdResp(regRdResp)
  );

endmodule

`default_nettype wire

// File: verification/axiLiteMaster.sv
`timescale 1ns/1ps
`default_nettype none

module axiLiteMaster #(
  parameter int unsigned AddrWidth = 12,
  parameter int unsigned DataWidth = 32
) (
  input  wire                     intf,
  // write address
  output logic [AddrWidth-1:0]    awAddr,
  output logic [2:0]              awProt,
  output logic                    awValid,
  input  wire                     awReady,
  // write data
  output logic [DataWidth-1:0]    wData,
  output logic [DataWidth/8-1:0]  wStrb,
  output logic                    wValid,
  input  wire                     wReady,
  // write response
  input  wire  axiLitePkg::respT  bResp,
  input  wire                     bValid,
  output logic                    bReady,
  // read address
  output logic [AddrWidth-1:0]    arAddr,
  output logic [2:0]              arProt,
  output logic                    arValid,
  input  wire                     arReady,
  // read data
  input  wire  [DataWidth-1:0]    rData,
  input  wire  axiLitePkg::respT  rResp,
  input  wire                     rValid,
  output logic                    rReady
);

  // idle bus from time 0, held through rst until the first transfer
  initial begin
    awAddr = '0;
    awProt = '0;
    awValid = 1'b0;
    wData = '0;
    wStrb = '1;
    wValid = 1'b0;
    bReady = 1'b0;
    arAddr = '0;
    arProt = '0;
    arValid = 1'b0;
    rReady = 1'b0;
  end

  ////////////////////////////////////////
  // channel transfers
  ////////////////////////////////////////

  // every task starts and ends 1 ns after a rising edge
  task automatic waitCycles(input int n);
    repeat (n) begin
      @(posedge intf);
      #1;
    end
  endtask

  task automatic awTransfer(input int delay, input logic [AddrWidth-1:0] addr);
    logic accepted;
    waitCycles(delay);
    awAddr = addr;
    // prot is driven but the slave ignores it
    awProt = 3'b010;
    awValid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      // ready seen here holds up to the next edge
      accepted = awReady;
      waitCycles(1);
    end
    awValid = 1'b0;
  endtask

  task automatic wTransfer(input int delay, input logic [DataWidth-1:0] data,
                           input logic [DataWidth/8-1:0] strb);
    logic accepted;
    waitCycles(delay);
    wData = data;
    wStrb = strb;
    wValid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = wReady;
      waitCycles(1);
    end
    wValid = 1'b0;
  endtask

  task automatic bTransfer(input int delay, output axiLitePkg::respT resp);
    logic seen;
    // bReady held back for the delay
    waitCycles(delay);
    bReady = 1'b1;
    seen = 1'b0;
    while (!seen) begin
      seen = bValid;
      resp = bResp;
      waitCycles(1);
    end
    bReady = 1'b0;
  endtask

  task automatic arTransfer(input int delay, input logic [AddrWidth-1:0] addr);
    logic accepted;
    waitCycles(delay);
    arAddr = addr;
    arProt = 3'b010;
    arValid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = arReady;
      waitCycles(1);
    end
    arValid = 1'b0;
  endtask

  task automatic rTransfer(input int delay, output logic [DataWidth-1:0] data,
                           output axiLitePkg::respT resp);
    logic seen;
    waitCycles(delay);
    rReady = 1'b1;
    seen = 1'b0;
    while (!seen) begin
      seen = rValid;
      data = rData;
      resp = rResp;
      waitCycles(1);
    end
    rReady = 1'b0;
  endtask

  ////////////////////////////////////////
  // whole transactions
  ////////////////////////////////////////

  // aw and w run side by side, so either may land first
  task automatic writeTransaction(input int awDelay, input int wDelay, input int bDelay,
                                  input logic [AddrWidth-1:0] addr,
                                  input logic [DataWidth-1:0] data,
                                  input logic [DataWidth/8-1:0] strb,
                                  output axiLitePkg::respT resp);
    fork
      awTransfer(awDelay, addr);
      wTransfer(wDelay, data, strb);
    join
    bTransfer(bDelay, resp);
  endtask

  task automatic readTransaction(input int arDelay, input int rDelay,
                                 input logic [AddrWidth-1:0] addr,
                                 output logic [DataWidth-1:0] data,
                                 output axiLitePkg::respT resp);
    arTransfer(arDelay, addr);
    rTransfer(rDelay, data, resp);
  endtask

endmodule

`default_nettype wire

// File: verification/regSubsystem_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module regSubsystem_asserts #(
  parameter int unsigned DataWidth = 32
) (
  input wire                    intf,
  input wire                    rst,
  input wire                    bValid,
  input wire                    bReady,
  input wire axiLitePkg::respT  bResp,
  input wire                    rValid,
  input wire                    rReady,
  input wire [DataWidth-1:0]    rData,
  input wire axiLitePkg::respT  rResp
);

  // b beat stays up and unchanged until taken
  assert property (@(posedge intf) disable iff (rst)
    bValid && !bReady |=> bValid && $stable(bResp))
    else $error("bValid dropped or bResp changed before bReady");

  // same for the r beat and its payload
  assert property (@(posedge intf) disable iff (rst)
    rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
    else $error("rValid dropped or rData/rResp changed before rReady");

  // no response pending right after reset
  assert property (@(posedge intf) $past(rst) && !rst |-> !bValid && !rValid)
    else $error("response valid high in the first cycle after reset");

endmodule

// attached to every regSubsystem instance
bind regSubsystem regSubsystem_asserts #(.DataWidth(DataWidth)) asserts0 (
  .intf(intf),
  .rst(rst),
  .bValid(bValid),
  .bReady(bReady),
  .bResp(bResp),
  .rValid(rValid),
  .rReady(rReady),
  .rData(rData),
  .rResp(rResp)
);

`default_nettype wire

// File: verification/regSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module regSubsystemTb;

  localparam int unsigned AddrWidth = axiLitePkg::DefaultAddrWidth;
  localparam int unsigned DataWidth = axiLitePkg::DefaultDataWidth;
  localparam int unsigned NumRegs = axiLitePkg::DefaultNumRegs;
  localparam int unsigned StrbWidth = DataWidth / 8;
  // well past the end of the map, still inside the address space
  localparam int unsigned OutOfRange = NumRegs + 192;
  // about 200 transactions at no more than 20 cycles each
  localparam int unsigned TimeoutCycles = 4000;

  typedef logic [DataWidth-1:0] wordT;
  typedef logic [StrbWidth-1:0] strbT;

  logic intf;
  logic rst;
  logic [AddrWidth-1:0] awAddr;
  logic [2:0] awProt;
  logic awValid;
  logic awReady;
  wordT wData;
  strbT wStrb;
  logic wValid;
  logic wReady;
  axiLitePkg::respT bResp;
  logic bValid;
  logic bReady;
  logic [AddrWidth-1:0] arAddr;
  logic [2:0] arProt;
  logic arValid;
  logic arReady;
  wordT rData;
  axiLitePkg::respT rResp;
  logic rValid;
  logic rReady;

  // reference state, index 0 and 1 of shadow unused
  wordT shadow [NumRegs];
  int unsigned okWrites;

  // expected responses in issue order
  axiLitePkg::respT expB [$];
  wordT expRData [$];
  axiLitePkg::respT expRResp [$];

  int unsigned cycleCount;
  int unsigned errorCount;
  logic verdictPrinted;

  regSubsystem #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .NumRegs(NumRegs)
  ) dut0 (
    .intf(intf), .rst(rst),
    .awAddr(awAddr), .awProt(awProt), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arProt(arProt), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady)
  );

  axiLiteMaster #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth)
  ) master0 (
    .intf(intf),
    .awAddr(awAddr), .awProt(awProt), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
    .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arProt(arProt), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady)
  );

  // 8 ns period
  initial begin
    intf = 1'b0;
    forever #4 intf = ~intf;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // only general registers take writes
  function automatic logic writeAccepted(input int unsigned index);
    return (index >= 2) && (index < NumRegs);
  endfunction

  function automatic wordT predictRead(input int unsigned index,
                                       output axiLitePkg::respT resp);
    wordT value;
    value = '0;
    resp = axiLitePkg::RespOkay;
    if (index == 0) begin
      value = wordT'(axiLitePkg::IdValue);
    end else if (index == 1) begin
      // counter wraps at the word width
      value = wordT'(okWrites);
    end else if (index < NumRegs) begin
      value = shadow[index];
    end else begin
      resp = axiLitePkg::RespSlvErr;
    end
    return value;
  endfunction

  // bytewise merge under the strobe
  function automatic void applyWrite(input int unsigned index, input wordT data,
                                     input strbT strb);
    if (writeAccepted(index)) begin
      okWrites++;
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) begin
          shadow[index][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
  endfunction

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic stopOnFailure(input string why);
    errorCount++;
    verdictPrinted = 1'b1;
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkEq(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      stopOnFailure($sformatf("FAILED %s: got %0h expected %0h", name, actual, expected));
    end
  endtask

  // responses sampled mid-cycle, the beat moves on the next edge
  always @(negedge intf) begin
    if (!rst && bValid) begin
      // aw and w held off while a write response waits
      checkEq("awReady", awReady, 1'b0);
      checkEq("wReady", wReady, 1'b0);
    end
    if (!rst && rValid) begin
      checkEq("arReady", arReady, 1'b0);
    end
    if (!rst && bValid && bReady) begin
      if (expB.size() == 0) begin
        stopOnFailure("write response arrived with no write outstanding");
      end else begin
        checkEq("bResp", bResp, expB.pop_front());
      end
    end
    if (!rst && rValid && rReady) begin
      if (expRData.size() == 0) begin
        stopOnFailure("read response arrived with no read outstanding");
      end else begin
        checkEq("rData", rData, expRData.pop_front());
        checkEq("rResp", rResp, expRResp.pop_front());
      end
    end
  end

  always @(posedge intf) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      stopOnFailure($sformatf("timeout: stimulus still running after %0d cycles", cycleCount));
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic timedWrite(input int unsigned index, input wordT data, input strbT strb,
                            input int awDelay, input int wDelay, input int bDelay);
    axiLitePkg::respT resp;
    expB.push_back(writeAccepted(index) ? axiLitePkg::RespOkay : axiLitePkg::RespSlvErr);
    master0.writeTransaction(awDelay, wDelay, bDelay, AddrWidth'(index * StrbWidth),
                             data, strb, resp);
    applyWrite(index, data, strb);
  endtask

  task automatic randomWrite(input int unsigned index, input wordT data, input strbT strb);
    timedWrite(index, data, strb, $urandom_range(3), $urandom_range(3), $urandom_range(4));
  endtask

  task automatic timedRead(input int unsigned index, input int arDelay, input int rDelay);
    wordT data;
    axiLitePkg::respT resp;
    data = predictRead(index, resp);
    expRData.push_back(data);
    expRResp.push_back(resp);
    master0.readTransaction(arDelay, rDelay, AddrWidth'(index * StrbWidth), data, resp);
  endtask

  task automatic randomRead(input int unsigned index);
    timedRead(index, $urandom_range(3), $urandom_range(4));
  endtask

  function automatic wordT randomWord();
    return wordT'({$urandom(), $urandom()});
  endfunction

  initial begin : stimulus
    int unsigned index;
    int unsigned order;
    strbT strb;
    void'($urandom(32'h5df));
    rst = 1'b1;
    cycleCount = 0;
    errorCount = 0;
    verdictPrinted = 1'b0;
    okWrites = 0;
    for (int i = 0; i < NumRegs; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(posedge intf);
    #1;
    // readies held low through reset
    checkEq("awReady", awReady, 1'b0);
    checkEq("wReady", wReady, 1'b0);
    checkEq("arReady", arReady, 1'b0);
    rst = 1'b0;
    // and up from the first edge out of reset
    @(posedge intf);
    #1;
    checkEq("awReady", awReady, 1'b1);
    checkEq("wReady", wReady, 1'b1);
    checkEq("arReady", arReady, 1'b1);

    // id, counter and zeroed registers out of reset
    for (index = 0; index < NumRegs; index++) begin
      randomRead(index);
    end

    // full strobes, read straight back
    for (index = 2; index < NumRegs; index++) begin
      randomWrite(index, randomWord(), '1);
      randomRead(index);
    end
    randomRead(1);

    // partial strobes merge into old contents
    repeat (30) begin
      index = $urandom_range(NumRegs - 1, 2);
      strb = strbT'($urandom());
      randomWrite(index, randomWord(), strb);
      randomRead(index);
    end
    randomRead(1);

    // refused writes leave the whole map alone
    randomWrite(0, randomWord(), '1);
    randomWrite(1, randomWord(), '1);
    randomWrite(OutOfRange, randomWord(), '1);
    for (index = 0; index < NumRegs; index++) begin
      randomRead(index);
    end
    randomRead(OutOfRange);

    // aw before, after and together with w, slow bReady and rReady
    repeat (40) begin
      index = $urandom_range(NumRegs - 1, 2);
      order = $urandom_range(2);
      strb = strbT'($urandom());
      case (order)
        0: timedWrite(index, randomWord(), strb, 0, 3, $urandom_range(6));
        1: timedWrite(index, randomWord(), strb, 3, 0, $urandom_range(6));
        default: timedWrite(index, randomWord(), strb, 0, 0, $urandom_range(6));
      endcase
      timedRead(index, $urandom_range(3), $urandom_range(6));
    end
    randomRead(1);

    // no extra response left waiting after the last beat
    checkEq("bValid", bValid, 1'b0);
    checkEq("rValid", rValid, 1'b0);

    verdictPrinted = 1'b1;
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // run ended before a verdict, e.g. on a bound assertion
  final begin
    if (!verdictPrinted) begin
      $display("tests failed");
    end
  end

endmodule

`default_nettype wire

// File: build.f
logic/axiLitePkg.sv
logic/axiLiteSlave.sv
logic/regBank.sv
logic/regSubsystem.sv
verification/axiLiteMaster.sv
verification/regSubsystem_asserts.sv
verification/regSubsystemTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then read the verdict from sim.log
verilator --binary --timing --assert -Wno-fatal --top-module regSubsystemTb -f build.f \
  || { echo "compile failed"; exit 1; }
./obj_dir/VregSubsystemTb > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
